/* build.f */
+incdir+verification
source/ladybird_bus_pkg.sv
source/ladybird_config_pkg.sv
source/ladybird_ram.sv
source/ladybird_serial_interface.sv
source/ladybird_crossbar.sv
source/ladybird_fabric_top.sv
verification/ladybird_tb.sv

/* source/ladybird_bus_pkg.sv */
package ladybird_bus_pkg;

  localparam int ADDR_W = 32;     // Byte address
  localparam int DATA_W = 32;     // Bus word
  localparam int BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BE_W-1:0]   byte_en_t;

  //////////////////////////////
  // Request from a master as a one-cycle strobe
  typedef struct packed {
    logic     valid;
    logic     we;            // Write when high
    byte_en_t be;            // One bit per byte lane
    addr_t    addr;
    word_t    wdata;
  } bus_req_t;

  //////////////////////////////
  // Response one cycle after the accepted request
  typedef struct packed {
    logic  rvalid;
    logic  err;              // Unmapped address
    word_t rdata;            // Zero for writes
  } bus_resp_t;

endpackage

/* source/ladybird_config_pkg.sv */
package ladybird_config_pkg;

  // Master indices
  localparam int I_BUS = 0;
  localparam int D_BUS = 1;

  //////////////////////////////
  // Address map
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [REGION_MSB-REGION_LSB:0] RAM_REGION  = 4'h9;
  localparam logic [REGION_MSB-REGION_LSB:0] UART_REGION = 4'hA;

  // 64 words repeated across the region
  localparam int RAM_ADDR_W = 6;

  //////////////////////////////
  // Serial interface
  localparam int UART_CLKS_PER_BIT = 16;

  // Byte offsets inside the UART region
  localparam logic [3:0] UART_TXDATA_OFS = 4'd0;
  localparam logic [3:0] UART_STATUS_OFS = 4'd4;
  localparam logic [3:0] UART_RXDATA_OFS = 4'd8;

  // Bit state of both serial machines
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_t;

endpackage

/* source/ladybird_crossbar.sv */
`timescale 1ns/100ps

module ladybird_crossbar
  import ladybird_bus_pkg::*;
  import ladybird_config_pkg::*;
  (
    input  logic      clk_i,
    input  logic      anrst_i,
    input  bus_req_t  i_req_i,
    input  bus_req_t  d_req_i,
    output logic      i_gnt_o,
    output logic      d_gnt_o,
    output bus_resp_t i_resp_o,
    output bus_resp_t d_resp_o,
    output bus_req_t  ram_req_o,
    output bus_req_t  uart_req_o,
    input  bus_resp_t ram_resp_i,
    input  bus_resp_t uart_resp_i
  );

  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_RAM,
    TGT_UART,
    TGT_ERR                                     // Unmapped region
  } target_t;

  bus_req_t  req   [2];
  bus_resp_t resp  [2];
  logic      gnt   [2];
  target_t   tgt   [2];                         // Decoded this cycle
  target_t   tag_q [2];                         // Target of last cycle
  logic      blocked;

  assign req[I_BUS] = i_req_i;
  assign req[D_BUS] = d_req_i;

  //////////////////////////////
  // Address decode

  always_comb begin : decode
    for (int m = 0; m < 2; m++) begin
      if (!req[m].valid) begin
        tgt[m] = TGT_NONE;
      end else begin
        case (req[m].addr[REGION_MSB:REGION_LSB])
          RAM_REGION:  tgt[m] = TGT_RAM;
          UART_REGION: tgt[m] = TGT_UART;
          default:     tgt[m] = TGT_ERR;
        endcase
      end
    end
  end

  //////////////////////////////
  // Fixed priority with D over I

  assign blocked = (tgt[I_BUS] == tgt[D_BUS]) &&
                   ((tgt[D_BUS] == TGT_RAM) || (tgt[D_BUS] == TGT_UART));

  assign gnt[D_BUS] = req[D_BUS].valid;
  assign gnt[I_BUS] = req[I_BUS].valid && !blocked;

  // On a clash D owns the port
  always_comb begin : target_mux
    ram_req_o        = (tgt[D_BUS] == TGT_RAM)  ? req[D_BUS] : req[I_BUS];
    uart_req_o       = (tgt[D_BUS] == TGT_UART) ? req[D_BUS] : req[I_BUS];
    ram_req_o.valid  = (tgt[D_BUS] == TGT_RAM)  || (tgt[I_BUS] == TGT_RAM);
    uart_req_o.valid = (tgt[D_BUS] == TGT_UART) || (tgt[I_BUS] == TGT_UART);
  end

  //////////////////////////////
  // Response steering

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      tag_q <= '{default: TGT_NONE};
    end else begin
      for (int m = 0; m < 2; m++) begin
        tag_q[m] <= gnt[m] ? tgt[m] : TGT_NONE;
      end
    end
  end

  always_comb begin : resp_mux
    for (int m = 0; m < 2; m++) begin
      case (tag_q[m])
        TGT_RAM:  resp[m] = ram_resp_i;
        TGT_UART: resp[m] = uart_resp_i;
        TGT_ERR:  resp[m] = '{rvalid: 1'b1, err: 1'b1, rdata: '0};  // Own answer
        default:  resp[m] = '0;
      endcase
    end
  end

  assign i_gnt_o  = gnt[I_BUS];
  assign d_gnt_o  = gnt[D_BUS];
  assign i_resp_o = resp[I_BUS];
  assign d_resp_o = resp[D_BUS];

endmodule

/* source/ladybird_fabric_top.sv */
`timescale 1ns/100ps

module ladybird_fabric_top
  import ladybird_bus_pkg::*;
  (
    input  logic      clk_i,
    input  logic      anrst_i,
    input  bus_req_t  i_req_i,
    input  bus_req_t  d_req_i,
    output logic      i_gnt_o,
    output logic      d_gnt_o,
    output bus_resp_t i_resp_o,
    output bus_resp_t d_resp_o,
    input  logic      uart_rx_i,
    output logic      uart_tx_o
  );

  bus_req_t  ram_req, uart_req;                 // Crossbar to targets
  bus_resp_t ram_resp, uart_resp;               // Targets back to crossbar

  ladybird_crossbar crossbar_i (
    .clk_i       (clk_i),
    .anrst_i     (anrst_i),
    .i_req_i     (i_req_i),
    .d_req_i     (d_req_i),
    .i_gnt_o     (i_gnt_o),
    .d_gnt_o     (d_gnt_o),
    .i_resp_o    (i_resp_o),
    .d_resp_o    (d_resp_o),
    .ram_req_o   (ram_req),
    .uart_req_o  (uart_req),
    .ram_resp_i  (ram_resp),
    .uart_resp_i (uart_resp)
  );

  ladybird_ram ram_i (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .req_i   (ram_req),
    .resp_o  (ram_resp)
  );

  ladybird_serial_interface uart_i (
    .clk_i     (clk_i),
    .anrst_i   (anrst_i),
    .req_i     (uart_req),
    .resp_o    (uart_resp),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

endmodule

/* source/ladybird_ram.sv */
`timescale 1ns/100ps

module ladybird_ram
  import ladybird_bus_pkg::*;
  import ladybird_config_pkg::*;
  (
    input  logic      clk_i,
    input  logic      anrst_i,
    input  bus_req_t  req_i,
    output bus_resp_t resp_o
  );

  word_t                 mem [2**RAM_ADDR_W];
  logic [RAM_ADDR_W-1:0] idx;
  logic                  rvalid_q;
  word_t                 rdata_q;

  assign idx = req_i.addr[RAM_ADDR_W+1:2];  // Word index with upper bits ignored

  // Byte lane merge on write
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Old contents are read and writes answer with zero
  always_ff @(posedge clk_i) begin
    rdata_q <= (req_i.valid && !req_i.we) ? mem[idx] : '0;
  end

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  assign resp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

/* source/ladybird_serial_interface.sv */
`timescale 1ns/100ps

module ladybird_serial_interface
  import ladybird_bus_pkg::*;
  import ladybird_config_pkg::*;
  (
    input  logic      clk_i,
    input  logic      anrst_i,
    input  bus_req_t  req_i,
    output bus_resp_t resp_o,
    input  logic      uart_rx_i,
    output logic      uart_tx_o
  );

  uart_state_t                       tx_state_q, rx_state_q;
  logic [$clog2(UART_CLKS_PER_BIT):0] tx_div_q, rx_div_q;  // Clock dividers
  logic [2:0]                        tx_bit_q, rx_bit_q;
  logic [7:0]                        tx_shift_q, rx_shift_q;
  logic [7:0]                        rx_data_q;
  logic                              rx_valid_q;
  logic                              rx_s1_q, rx_s2_q;     // Input synchronizer
  logic                              tx_busy;
  logic                              wr_tx, rd_rx;
  logic [3:0]                        ofs;
  logic                              rvalid_q;
  word_t                             rdata_q;

  assign ofs     = req_i.addr[3:0];
  assign wr_tx   = req_i.valid && req_i.we && (ofs == UART_TXDATA_OFS);
  assign rd_rx   = req_i.valid && !req_i.we && (ofs == UART_RXDATA_OFS);
  assign tx_busy = (tx_state_q != IDLE);

  //////////////////////////////
  // Transmitter

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      tx_state_q <= IDLE;
      tx_div_q   <= '0;
      tx_bit_q   <= '0;
      tx_shift_q <= '0;
    end else begin
      tx_div_q <= tx_div_q + 1'b1;
      case (tx_state_q)
        IDLE: begin
          tx_div_q <= '0;
          if (wr_tx) begin                      // Write while busy is dropped
            tx_shift_q <= req_i.wdata[7:0];
            tx_state_q <= START;
          end
        end
        START: begin
          if (tx_div_q == UART_CLKS_PER_BIT - 1) begin
            tx_div_q   <= '0;
            tx_bit_q   <= '0;
            tx_state_q <= DATA;
          end
        end
        DATA: begin
          if (tx_div_q == UART_CLKS_PER_BIT - 1) begin
            tx_div_q   <= '0;
            tx_shift_q <= tx_shift_q >> 1;      // LSB first
            tx_bit_q   <= tx_bit_q + 1'b1;
            if (tx_bit_q == 3'd7) begin
              tx_state_q <= STOP;
            end
          end
        end
        default: begin
          if (tx_div_q == UART_CLKS_PER_BIT - 1) begin
            tx_state_q <= IDLE;
          end
        end
      endcase
    end
  end

  assign uart_tx_o = (tx_state_q == START) ? 1'b0 :
                     (tx_state_q == DATA)  ? tx_shift_q[0] : 1'b1;

  //////////////////////////////
  // Receiver

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      rx_s1_q    <= 1'b1;
      rx_s2_q    <= 1'b1;
      rx_state_q <= IDLE;
      rx_div_q   <= '0;
      rx_bit_q   <= '0;
      rx_shift_q <= '0;
      rx_data_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_s1_q  <= uart_rx_i;
      rx_s2_q  <= rx_s1_q;
      rx_div_q <= rx_div_q + 1'b1;
      if (rd_rx) begin
        rx_valid_q <= 1'b0;                     // Cleared by the RXDATA read
      end
      case (rx_state_q)
        IDLE: begin
          rx_div_q <= '0;
          if (!rx_s2_q) begin
            rx_state_q <= START;
          end
        end
        START: begin
          if (rx_div_q == UART_CLKS_PER_BIT / 2 - 1) begin  // Middle of start bit
            rx_div_q   <= '0;
            rx_bit_q   <= '0;
            rx_state_q <= rx_s2_q ? IDLE : DATA;          // Glitch goes back
          end
        end
        DATA: begin
          if (rx_div_q == UART_CLKS_PER_BIT - 1) begin
            rx_div_q   <= '0;
            rx_shift_q <= {rx_s2_q, rx_shift_q[7:1]};
            rx_bit_q   <= rx_bit_q + 1'b1;
            if (rx_bit_q == 3'd7) begin
              rx_state_q <= STOP;
            end
          end
        end
        default: begin
          // Runs to the end of the stop bit
          if (rx_div_q == UART_CLKS_PER_BIT + UART_CLKS_PER_BIT / 2 - 1) begin
            rx_data_q  <= rx_shift_q;           // Overwrites an unread byte
            rx_valid_q <= 1'b1;
            rx_state_q <= IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Register read back

  always_ff @(posedge clk_i) begin
    rdata_q <= '0;
    if (req_i.valid && !req_i.we) begin
      case (ofs)
        UART_STATUS_OFS: rdata_q <= {{(DATA_W-2){1'b0}}, rx_valid_q, tx_busy};
        UART_RXDATA_OFS: rdata_q <= {{(DATA_W-8){1'b0}}, rx_data_q};
        default:         rdata_q <= '0;        // TXDATA and holes
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.valid;
    end
  end

  assign resp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

/* verification/ladybird_tb_bus_helpers.svh */
//////////////////////////////
// Bus helpers

function automatic bus_req_t make_req(input logic we, input byte_en_t be, input addr_t addr,
                                      input word_t wdata);
  bus_req_t req;
  req.valid = 1'b1;
  req.we    = we;
  req.be    = be;
  req.addr  = addr;
  req.wdata = wdata;
  return req;
endfunction

// Random bits above the word index since the RAM repeats across its region
function automatic addr_t ram_addr(input int idx);
  addr_t addr;
  addr                          = $urandom;
  addr[REGION_MSB:REGION_LSB]   = RAM_REGION;
  addr[RAM_ADDR_W+1:2]          = idx[RAM_ADDR_W-1:0];
  addr[1:0]                     = 2'b00;
  return addr;
endfunction

function automatic addr_t uart_addr(input logic [3:0] ofs);
  addr_t addr;
  addr                        = '0;
  addr[REGION_MSB:REGION_LSB] = UART_REGION;
  addr[3:0]                   = ofs;
  return addr;
endfunction

function automatic word_t merge_bytes(input word_t old, input word_t wdata, input byte_en_t be);
  word_t res;
  res = old;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      res[8*b +: 8] = wdata[8*b +: 8];
    end
  end
  return res;
endfunction

// Requests on both ports for one cycle and their responses one cycle later
task automatic pair_access(input bus_req_t ireq, input bus_req_t dreq,
                           output logic igrant, output logic dgrant,
                           output bus_resp_t iresp, output bus_resp_t dresp);
  @(posedge clk_i);
  i_req <= ireq;
  d_req <= dreq;
  @(negedge clk_i);
  igrant = i_gnt;
  dgrant = d_gnt;
  check_value("i_resp_o.rvalid", i_resp.rvalid, 0);  // Not before the accepting edge
  check_value("d_resp_o.rvalid", d_resp.rvalid, 0);
  @(posedge clk_i);
  i_req <= '0;
  d_req <= '0;
  @(negedge clk_i);
  iresp = i_resp;
  dresp = d_resp;
endtask

task automatic bus_access(input logic use_d, input logic we, input byte_en_t be,
                          input addr_t addr, input word_t wdata, output bus_resp_t resp);
  bus_req_t  req;
  logic      ig, dg;
  bus_resp_t ir, dr;
  req = make_req(we, be, addr, wdata);
  if (use_d) begin
    pair_access('0, req, ig, dg, ir, dr);
    check_value("d_gnt_o", dg, 1);
    resp = dr;
  end else begin
    pair_access(req, '0, ig, dg, ir, dr);
    check_value("i_gnt_o", ig, 1);
    resp = ir;
  end
endtask

task automatic wait_cycle(input int unsigned target);
  while (cycle_cnt < target) begin
    @(negedge clk_i);
  end
endtask

/* verification/ladybird_tb_tests.svh */
//////////////////////////////
// Directed tests

task automatic idle_after_reset();
  int        err_start;
  bus_resp_t resp;
  err_start = errors;
  repeat (3) begin
    @(negedge clk_i);
    check_value("i_resp_o.rvalid", i_resp.rvalid, 0);
    check_value("d_resp_o.rvalid", d_resp.rvalid, 0);
    check_value("uart_tx_o", uart_tx, 1);
  end
  bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_STATUS_OFS), '0, resp);
  check_value("d_resp_o.rvalid", resp.rvalid, 1);
  check_value("d_resp_o.err", resp.err, 0);
  check_value("STATUS", resp.rdata, 0);
  report_test("idle_after_reset", err_start);
endtask

task automatic ram_write_read();
  int        err_start;
  int        idx;
  byte_en_t  be;
  word_t     data;
  bus_resp_t resp;
  err_start = errors;
  for (int n = 0; n < RAM_WRITES; n++) begin
    idx  = $urandom_range(2**RAM_ADDR_W - 1);
    be   = ram_known[idx] ? byte_en_t'($urandom) : 4'hF;  // First write fills the word
    data = $urandom;
    bus_access(1'b1, 1'b1, be, ram_addr(idx), data, resp);
    check_value("d_resp_o.rvalid", resp.rvalid, 1);
    check_value("d_resp_o.rdata", resp.rdata, 0);
    ram_model[idx] = merge_bytes(ram_model[idx], data, be);
    if (!ram_known[idx]) begin
      written_q.push_back(idx);
    end
    ram_known[idx] = 1'b1;
  end
  foreach (written_q[n]) begin
    bus_access(1'b1, 1'b0, 4'hF, ram_addr(written_q[n]), '0, resp);
    check_value("d_resp_o.rvalid", resp.rvalid, 1);
    check_value("d_resp_o.err", resp.err, 0);
    check_value("d_resp_o.rdata", resp.rdata, ram_model[written_q[n]]);
  end
  report_test("ram_write_read", err_start);
endtask

task automatic arbitrate_masters();
  int        err_start;
  int        rd_idx;
  int        wr_idx;
  word_t     data;
  logic      ig, dg;
  bus_resp_t ir, dr;
  bus_req_t  rd_req;
  err_start = errors;
  rd_idx = written_q[0];
  rd_req = make_req(1'b0, 4'hF, ram_addr(rd_idx), '0);
  // Different targets with D on an unused UART offset
  pair_access(rd_req, make_req(1'b1, 4'hF, uart_addr(4'hC), $urandom), ig, dg, ir, dr);
  check_value("i_gnt_o", ig, 1);
  check_value("d_gnt_o", dg, 1);
  check_value("i_resp_o.rvalid", ir.rvalid, 1);
  check_value("i_resp_o.err", ir.err, 0);
  check_value("i_resp_o.rdata", ir.rdata, ram_model[rd_idx]);
  check_value("d_resp_o.rvalid", dr.rvalid, 1);
  check_value("d_resp_o.err", dr.err, 0);
  check_value("d_resp_o.rdata", dr.rdata, 0);
  // Same target where D wins and I repeats
  wr_idx = written_q[$];
  data   = $urandom;
  @(posedge clk_i);
  i_req <= rd_req;
  d_req <= make_req(1'b1, 4'hF, ram_addr(wr_idx), data);
  @(negedge clk_i);
  check_value("d_gnt_o", d_gnt, 1);
  check_value("i_gnt_o", i_gnt, 0);
  @(posedge clk_i);
  d_req <= '0;                                   // I holds its request
  @(negedge clk_i);
  ram_model[wr_idx] = data;
  check_value("i_gnt_o", i_gnt, 1);
  check_value("d_resp_o.rvalid", d_resp.rvalid, 1);
  check_value("d_resp_o.rdata", d_resp.rdata, 0);
  check_value("i_resp_o.rvalid", i_resp.rvalid, 0);
  @(posedge clk_i);
  i_req <= '0;
  @(negedge clk_i);
  check_value("i_resp_o.rvalid", i_resp.rvalid, 1);
  check_value("i_resp_o.rdata", i_resp.rdata, ram_model[rd_idx]);
  report_test("arbitrate_masters", err_start);
endtask

task automatic unmapped_access();
  int        err_start;
  addr_t     addr;
  string     port_name;
  bus_resp_t resp;
  err_start = errors;
  for (int port = 0; port < 2; port++) begin
    addr                        = $urandom;
    addr[REGION_MSB:REGION_LSB] = 4'h3;
    port_name                   = (port == D_BUS) ? "d_resp_o" : "i_resp_o";
    bus_access(port == D_BUS, port == D_BUS, 4'hF, addr, $urandom, resp);
    check_value({port_name, ".rvalid"}, resp.rvalid, 1);
    check_value({port_name, ".err"}, resp.err, 1);
    check_value({port_name, ".rdata"}, resp.rdata, 0);
  end
  report_test("unmapped_access", err_start);
endtask

task automatic uart_transmit();
  int          err_start;
  int unsigned start;
  logic [7:0]  tx_byte;
  logic [9:0]  frame;
  bus_resp_t   resp;
  err_start = errors;
  tx_byte = 8'($urandom);
  frame   = {1'b1, tx_byte, 1'b0};               // Sent from bit 0 up
  bus_access(1'b1, 1'b1, 4'h1, uart_addr(UART_TXDATA_OFS), {24'h0, tx_byte}, resp);
  start = cycle_cnt;                             // Edge that took the write
  bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_STATUS_OFS), '0, resp);
  check_value("STATUS", resp.rdata, 32'h1);
  for (int k = 0; k < 10; k++) begin
    wait_cycle(start + UART_CLKS_PER_BIT * k + UART_CLKS_PER_BIT / 2);
    check_value($sformatf("uart_tx_o bit %0d", k), uart_tx, frame[k]);
    if (k == 2) begin
      bus_access(1'b1, 1'b1, 4'h1, uart_addr(UART_TXDATA_OFS), {24'h0, ~tx_byte}, resp);
    end
  end
  wait_cycle(start + FRAME_CYCLES + 1);
  check_value("uart_tx_o", uart_tx, 1);
  bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_STATUS_OFS), '0, resp);
  check_value("STATUS", resp.rdata, 0);
  report_test("uart_transmit", err_start);
endtask

task automatic uart_receive();
  int          err_start;
  int unsigned start;
  logic [7:0]  rx_byte;
  logic [9:0]  frame;
  logic        seen;
  bus_resp_t   resp;
  err_start = errors;
  rx_byte = 8'($urandom);
  frame   = {1'b1, rx_byte, 1'b0};
  for (int k = 0; k < 10; k++) begin
    @(posedge clk_i);
    uart_rx <= frame[k];
    repeat (UART_CLKS_PER_BIT - 1) @(posedge clk_i);
  end
  start = cycle_cnt;
  seen  = 1'b0;
  while (!seen && (cycle_cnt - start < 200)) begin
    bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_STATUS_OFS), '0, resp);
    seen = resp.rdata[1];
  end
  if (!seen) begin
    errors++;
    $display("Failure at %0t ns: the received byte was not flagged within 200 cycles", $time);
  end else begin
    bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_RXDATA_OFS), '0, resp);
    check_value("RXDATA", resp.rdata, {24'h0, rx_byte});
    bus_access(1'b1, 1'b0, 4'hF, uart_addr(UART_STATUS_OFS), '0, resp);
    check_value("STATUS", resp.rdata, 0);
  end
  report_test("uart_receive", err_start);
endtask

/* verification/ladybird_tb.sv */
`timescale 1ns/100ps

module ladybird_tb
  import ladybird_bus_pkg::*;
  import ladybird_config_pkg::*;
  ();

  localparam int CLK_PERIOD    = 20;
  localparam int RAM_WRITES    = 20;
  localparam int FRAME_CYCLES  = 10 * UART_CLKS_PER_BIT;  // Start, 8 data, stop
  localparam int ACCESS_CYCLES = 2;
  localparam int RUN_CYCLES    = 3 * FRAME_CYCLES + (2 * RAM_WRITES + 20) * ACCESS_CYCLES + 200;
  localparam int WATCHDOG_NS   = (RUN_CYCLES + 100) * CLK_PERIOD;

  logic        clk_i;
  logic        anrst_i;
  bus_req_t    i_req, d_req;
  logic        i_gnt, d_gnt;
  bus_resp_t   i_resp, d_resp;
  logic        uart_rx;
  logic        uart_tx;

  int unsigned cycle_cnt;                        // Rising edges since time zero
  int          checks;
  int          errors;
  word_t       ram_model [2**RAM_ADDR_W];        // Reference RAM
  bit          ram_known [2**RAM_ADDR_W];
  int          written_q [$];

  ladybird_fabric_top dut_i (
    .clk_i     (clk_i),
    .anrst_i   (anrst_i),
    .i_req_i   (i_req),
    .d_req_i   (d_req),
    .i_gnt_o   (i_gnt),
    .d_gnt_o   (d_gnt),
    .i_resp_o  (i_resp),
    .d_resp_o  (d_resp),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////
  // Watchdog

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("%-18s finished, %0d errors", name, errors - err_start);
  endtask

  `include "ladybird_tb_bus_helpers.svh"
  `include "ladybird_tb_tests.svh"

  //////////////////////////////
  // Test sequence

  initial begin
    clk_i     = 1'b0;
    anrst_i   = 1'b0;
    i_req     = '0;
    d_req     = '0;
    uart_rx   = 1'b1;                            // Idle line
    cycle_cnt = 0;
    checks    = 0;
    errors    = 0;
    void'($urandom(52758));
    repeat (4) @(posedge clk_i);
    anrst_i <= 1'b1;
    idle_after_reset();
    ram_write_read();
    arbitrate_masters();
    unmapped_access();
    uart_transmit();
    uart_receive();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
